/* Makefile */
# Verilator build and run of the microprocessor testbench.
# Run from the project root, the testbench opens its stimulus file by relative path.

VERILATOR ?= verilator
TOP       ?= upTb
STIM      ?= verif/upStim.txt
FILELIST  ?= files.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# a $fatal in the testbench gives a non-zero exit status, so make fails with it.
sim: $(STIM) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o V$(TOP)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

/* files.f */
src/cpuPkg.sv
src/memPkg.sv
src/upMemory.sv
src/upDatapath.sv
src/upControl.sv
src/upTop.sv
verif/upTb.sv

/* src/cpuPkg.sv */
package cpuPkg;

	// instruction set of the 8-bit core.
	typedef enum logic [2:0] {
		opHlt = 3'd0, // stop and return to idle.
		opLdi = 3'd1, // r0 <= zero-extended imm.
		opAdd = 3'd2, // rd <= rd + rs.
		opSub = 3'd3, // rd <= rd - rs.
		opMov = 3'd4, // rd <= rs.
		opLd  = 3'd5, // rd <= mem[rs].
		opSt  = 3'd6, // mem[rs] <= rd.
		opJnz = 3'd7  // pc <= imm when zero flag is clear.
	} opcodeT;

	localparam int regIdxW = 2;
	localparam int numRegs = 4;

	// two-register layout.
	typedef struct packed {
		opcodeT               op;
		logic [regIdxW-1:0]   rd;
		logic [regIdxW-1:0]   rs;
		logic                 unused; // spare bit ignored by decode.
	} regFormT;

	// immediate layout for ldi and jnz.
	typedef struct packed {
		opcodeT     op;
		logic [4:0] imm;
	} immFormT;

	// the same byte seen through both layouts.
	typedef union packed {
		regFormT regForm;
		immFormT immForm;
	} instrT;

endpackage

/* src/memPkg.sv */
package memPkg;

	localparam int dataW = 8;
	localparam int addrW = 8;

	localparam int memDepth   = 256;
	localparam int resetDepth = 128; // only the low half is cleared on reset.

	// writes here go to the output port, not the array.
	localparam logic [addrW-1:0] ioOutAddr = 8'hFF;

	// boot program placed at address 0.
	localparam logic [dataW-1:0] bootImage [0:7] = '{
		8'h45,
		8'h64,
		8'h24,
		8'h24,
		8'h24,
		8'h26,
		8'h04,
		8'h56
	};

endpackage

/* src/upControl.sv */
module upControl (
	input  logic                        clk,
	input  logic                        nRst,
	input  logic                        run,
	input  logic                        loadEn,
	input  logic [memPkg::addrW-1:0]    loadAddr,
	input  logic [memPkg::dataW-1:0]    loadData,
	input  logic [memPkg::dataW-1:0]    memRdata,
	input  logic [memPkg::dataW-1:0]    rdVal,
	input  logic [memPkg::dataW-1:0]    rsVal,
	input  logic                        zero,
	output logic                        running,
	output logic [memPkg::addrW-1:0]    memAddr,
	output logic                        memWe,
	output logic [memPkg::dataW-1:0]    memWdata,
	output logic [cpuPkg::regIdxW-1:0]  rdSel,
	output logic [cpuPkg::regIdxW-1:0]  rsSel,
	output cpuPkg::opcodeT              aluOp,
	output logic                        regWe,
	output logic                        wbSrc,
	output logic [4:0]                  imm,
	output logic                        flagWe
);

	import cpuPkg::*;
	import memPkg::*;

	typedef enum logic [1:0] {
		sIdle,
		sFetch,
		sExec
	} stateT;

	stateT            state;
	logic [addrW-1:0] pc;
	instrT            ir;
	opcodeT           op;
	logic             isMemOp;
	logic             takeJump;

	// the register view carries the opcode for both forms.
	assign op       = ir.regForm.op;
	assign isMemOp  = (op == opLd) || (op == opSt);
	assign takeJump = (op == opJnz) && !zero;
	assign running  = (state != sIdle);

	// field decode for the execute cycle.
	assign rdSel = ir.regForm.rd;
	assign rsSel = ir.regForm.rs;
	assign imm   = ir.immForm.imm;
	assign aluOp = op;
	assign wbSrc = (op == opLd);

	always_comb begin
		regWe  = 1'b0;
		flagWe = 1'b0;
		if (state == sExec) begin
			case (op)
				opLdi, opAdd, opSub: begin
					regWe  = 1'b1;
					flagWe = 1'b1;
				end
				opMov, opLd: regWe = 1'b1;
				default: ;
			endcase
		end
	end

	// the bus goes to the load port when idle, to pc on fetch and to rs for ld/st.
	always_comb begin
		case (state)
			sIdle: begin
				memAddr  = loadAddr;
				memWe    = loadEn;
				memWdata = loadData;
			end
			sExec: begin
				memAddr  = isMemOp ? rsVal : pc;
				memWe    = (op == opSt);
				memWdata = rdVal;
			end
			default: begin
				memAddr  = pc;
				memWe    = 1'b0;
				memWdata = rdVal;
			end
		endcase
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state <= sIdle;
			pc    <= '0;
			ir    <= '0;
		end else begin
			case (state)
				sIdle: begin
					if (run) begin
						state <= sFetch;
						pc    <= '0; // programs always start at 0.
					end
				end
				sFetch: begin
					ir    <= memRdata;
					state <= sExec;
				end
				sExec: begin
					if (takeJump) begin
						pc <= addrW'(ir.immForm.imm);
					end else begin
						pc <= pc + 1'b1;
					end
					state <= (op == opHlt) ? sIdle : sFetch;
				end
				default: state <= sIdle;
			endcase
		end
	end

endmodule

/* src/upDatapath.sv */
module upDatapath (
	input  logic                        clk,
	input  logic                        nRst,
	input  logic [cpuPkg::regIdxW-1:0]  rdSel,
	input  logic [cpuPkg::regIdxW-1:0]  rsSel,
	input  cpuPkg::opcodeT              aluOp,
	input  logic                        regWe,
	input  logic                        wbSrc,
	input  logic [4:0]                  imm,
	input  logic [memPkg::dataW-1:0]    memRdata,
	input  logic                        flagWe,
	output logic [memPkg::dataW-1:0]    rdVal,
	output logic [memPkg::dataW-1:0]    rsVal,
	output logic                        zero
);

	import cpuPkg::*;
	import memPkg::*;

	logic [dataW-1:0]   regs [0:numRegs-1];
	logic [dataW-1:0]   aluRes;
	logic [dataW-1:0]   wbVal;
	logic [regIdxW-1:0] wrIdx;

	assign rdVal = regs[rdSel];
	assign rsVal = regs[rsSel];

	always_comb begin
		case (aluOp)
			opAdd:   aluRes = rdVal + rsVal;
			opSub:   aluRes = rdVal - rsVal;
			opMov:   aluRes = rsVal;
			opLdi:   aluRes = {{(dataW-5){1'b0}}, imm};
			default: aluRes = rdVal;
		endcase
	end

	assign wbVal = wbSrc ? memRdata : aluRes; // memory load or alu.

	// ldi always targets r0 whatever the rd bits say.
	assign wrIdx = (aluOp == opLdi) ? '0 : rdSel;

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (regWe) begin
			regs[wrIdx] <= wbVal;
		end
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			zero <= 1'b0;
		end else if (flagWe) begin
			zero <= (aluRes == '0);
		end
	end

endmodule

/* src/upMemory.sv */
module upMemory (
	input  logic                      clk,
	input  logic                      nRst,
	input  logic [memPkg::addrW-1:0]  addr,
	input  logic                      we,
	input  logic [memPkg::dataW-1:0]  wdata,
	output logic [memPkg::dataW-1:0]  rdata,
	output logic                      outValid,
	output logic [memPkg::dataW-1:0]  outData
);

	import memPkg::*;

	logic [dataW-1:0] mem [0:memDepth-1];
	logic             ioHit;

	assign ioHit = (addr == ioOutAddr);
	assign rdata = mem[addr]; // combinational read.

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			for (int i = 0; i < $size(bootImage); i++) begin
				mem[i] <= bootImage[i];
			end
			for (int i = $size(bootImage); i < resetDepth; i++) begin
				mem[i] <= '0;
			end
		end else begin
			if (we && !ioHit) begin
				mem[addr] <= wdata;
			end
		end
	end

	// output port register.
	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			outValid <= 1'b0;
			outData  <= '0;
		end else begin
			outValid <= we && ioHit; // one-cycle pulse per store.
			if (we && ioHit) begin
				outData <= wdata;
			end
		end
	end

endmodule

/* src/upTop.sv */
module upTop (
	input  logic                      clk,
	input  logic                      nRst,
	input  logic                      run,
	input  logic                      loadEn,
	input  logic [memPkg::addrW-1:0]  loadAddr,
	input  logic [memPkg::dataW-1:0]  loadData,
	output logic                      running,
	output logic [memPkg::dataW-1:0]  rdData,
	output logic                      outValid,
	output logic [memPkg::dataW-1:0]  outData
);

	import cpuPkg::*;
	import memPkg::*;

	logic [addrW-1:0]   memAddr;
	logic               memWe;
	logic [dataW-1:0]   memWdata;
	logic [dataW-1:0]   memRdata;
	logic [regIdxW-1:0] rdSel;
	logic [regIdxW-1:0] rsSel;
	opcodeT             aluOp;
	logic               regWe;
	logic               wbSrc;
	logic [4:0]         imm;
	logic               flagWe;
	logic [dataW-1:0]   rdVal;
	logic [dataW-1:0]   rsVal;
	logic               zero;

	assign rdData = memRdata; // shows loadAddr while idle.

	upControl control (
		.clk(clk),
		.nRst(nRst),
		.run(run),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.memRdata(memRdata),
		.rdVal(rdVal),
		.rsVal(rsVal),
		.zero(zero),
		.running(running),
		.memAddr(memAddr),
		.memWe(memWe),
		.memWdata(memWdata),
		.rdSel(rdSel),
		.rsSel(rsSel),
		.aluOp(aluOp),
		.regWe(regWe),
		.wbSrc(wbSrc),
		.imm(imm),
		.flagWe(flagWe)
	);

	upDatapath datapath (
		.clk(clk),
		.nRst(nRst),
		.rdSel(rdSel),
		.rsSel(rsSel),
		.aluOp(aluOp),
		.regWe(regWe),
		.wbSrc(wbSrc),
		.imm(imm),
		.memRdata(memRdata),
		.flagWe(flagWe),
		.rdVal(rdVal),
		.rsVal(rsVal),
		.zero(zero)
	);

	upMemory memory (
		.clk(clk),
		.nRst(nRst),
		.addr(memAddr),
		.we(memWe),
		.wdata(memWdata),
		.rdata(memRdata),
		.outValid(outValid),
		.outData(outData)
	);

endmodule

/* verif/upStim.txt */
# cmd arg1 arg2, bytes and addresses in hex, the counts of R and Z in decimal.
# W addr data = load write, C addr value = readback, X value = expected output.
# R n = run to halt with a second run strobe after n cycles (0 = none), Z n = random zero checks.
# boot image after reset.
C 00 45
C 01 64
C 02 24
C 03 24
C 04 24
C 05 26
C 06 04
C 07 56
Z 12
# arithmetic program, r3 = 0 - 1 is the output port address.
W 00 21
W 01 98
W 02 20
W 03 66
W 04 98
W 05 27
W 06 88
W 07 25
W 08 48
W 09 CE
W 0A 68
W 0B CE
W 0C 92
W 0D 54
W 0E 52
W 0F D6
W 10 3F
W 11 C6
W 12 00
X 0C
X 07
X 15
X 1F
R 10
# countdown from 4 with sub and jnz.
W 00 21
W 01 98
W 02 88
W 03 20
W 04 66
W 05 98
W 06 24
W 07 C6
W 08 62
W 09 E7
W 0A C6
W 0B 00
X 04
X 03
X 02
X 01
X 00
R 0
# copy 18..19 to 1C..1D with ld and st.
W 18 A5
W 19 3C
W 00 38
W 01 A8
W 02 3C
W 03 C8
W 04 39
W 05 A8
W 06 3D
W 07 C8
W 08 00
R 0
C 1C A5
C 1D 3C
C 18 A5
C 19 3C
C 01 A8
C 03 C8
C 07 C8

/* verif/upTb.sv */
module upTb;

	import memPkg::*;

	localparam int resetCycles = 8;
	localparam int runLimit    = 2000; // cycles allowed for one program.

	logic             clk;
	logic             nRst;
	logic             run;
	logic             loadEn;
	logic [addrW-1:0] loadAddr;
	logic [dataW-1:0] loadData;
	logic             running;
	logic [dataW-1:0] rdData;
	logic             outValid;
	logic [dataW-1:0] outData;

	logic [31:0]      rngState = 32'h87ad8d5e;
	logic [dataW-1:0] expQ [$]; // expected output port bytes in order.
	logic [dataW-1:0] expOut;

	upTop UUT (
		.clk(clk),
		.nRst(nRst),
		.run(run),
		.loadEn(loadEn),
		.loadAddr(loadAddr),
		.loadData(loadData),
		.running(running),
		.rdData(rdData),
		.outValid(outValid),
		.outData(outData)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic failNow(input string line);
		$display("%s", line);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// lcg with the usual 32-bit constants.
	function automatic logic [31:0] nextRand();
		rngState = rngState * 32'd1664525 + 32'd1013904223;
		return rngState;
	endfunction

	task automatic writeByte(input logic [addrW-1:0] a, input logic [dataW-1:0] d);
		@(posedge clk);
		loadEn   <= 1'b1;
		loadAddr <= a;
		loadData <= d;
		@(posedge clk);
		loadEn <= 1'b0;
	endtask

	task automatic readByte(input logic [addrW-1:0] a, output logic [dataW-1:0] got);
		@(posedge clk);
		loadAddr <= a;
		@(negedge clk); // combinational read has settled.
		got = rdData;
	endtask

	task automatic checkByte(input logic [addrW-1:0] a, input logic [dataW-1:0] want);
		logic [dataW-1:0] got;
		readByte(a, got);
		assert (got === want) else failNow($sformatf(
			"[FAIL] %0t: mem[0x%02h] read 0x%02h, expected 0x%02h", $time, a, got, want));
	endtask

	task automatic zeroChecks(input int count);
		logic [31:0]      r;
		logic [addrW-1:0] a;
		logic [dataW-1:0] d;
		for (int k = 0; k < count; k++) begin
			r = nextRand();
			a = addrW'(8 + (r[23:16] % 120)); // cleared region above the boot bytes.
			d = r[31:24];
			checkByte(a, '0);
			writeByte(a, d);
			checkByte(a, d);
			writeByte(a, '0);
		end
	endtask

	task automatic runProgram(input int extra);
		logic [dataW-1:0] ioBefore;
		logic [dataW-1:0] ioAfter;
		int               cycles;
		readByte(ioOutAddr, ioBefore); // array cell behind the output port.
		@(posedge clk);
		run <= 1'b1;
		@(posedge clk);
		run <= 1'b0;
		@(negedge clk);
		assert (running === 1'b1) else failNow($sformatf(
			"[FAIL] %0t: running did not rise on the edge after the run strobe", $time));
		cycles = 0;
		while (running === 1'b1) begin
			if (extra > 0 && cycles == extra) begin
				@(posedge clk); // strobe again while busy.
				run <= 1'b1;
				@(posedge clk);
				run <= 1'b0;
			end
			@(negedge clk);
			cycles++;
			if (cycles > runLimit) failNow("timeout while waiting for the program to halt");
		end
		readByte(ioOutAddr, ioAfter);
		assert (ioAfter === ioBefore) else failNow($sformatf(
			"[FAIL] %0t: mem[0xff] changed to 0x%02h by a run", $time, ioAfter));
		if (expQ.size() != 0) failNow($sformatf(
			"program halted with %0d expected output bytes never seen", expQ.size()));
	endtask

	task automatic requireArgs(input int got, input int want);
		if (got != want) failNow("malformed command line in verif/upStim.txt");
	endtask

	// output port monitor.
	always @(negedge clk) begin
		if (nRst === 1'b1 && outValid === 1'b1) begin
			if (expQ.size() == 0) begin
				failNow("output port pulsed while no expected output byte was queued");
			end else begin
				expOut = expQ.pop_front();
				assert (outData === expOut) else failNow($sformatf(
					"[FAIL] %0t: output 0x%02h, expected 0x%02h", $time, outData, expOut));
			end
		end
	end

	initial begin
		int               fd;
		int               code;
		int               n;
		logic [8*32-1:0]  cmd;
		logic [8*128-1:0] rest;
		logic [addrW-1:0] a;
		logic [dataW-1:0] d;
		nRst     = 1'b0;
		run      = 1'b0;
		loadEn   = 1'b0;
		loadAddr = '0;
		loadData = '0;
		repeat (resetCycles) @(posedge clk);
		nRst <= 1'b1;
		@(negedge clk);
		assert (running === 1'b0 && outValid === 1'b0 && outData === '0) else failNow(
			$sformatf("[FAIL] %0t: running, outValid or outData not cleared by reset", $time));
		fd = $fopen("verif/upStim.txt", "r");
		if (fd == 0) failNow("could not open verif/upStim.txt");
		while (!$feof(fd)) begin
			code = $fscanf(fd, "%s", cmd);
			if (code != 1) break;
			case (cmd)
				"#": code = $fgets(rest, fd); // comment line.
				"W": begin
					code = $fscanf(fd, "%h %h", a, d);
					requireArgs(code, 2);
					writeByte(a, d);
				end
				"C": begin
					code = $fscanf(fd, "%h %h", a, d);
					requireArgs(code, 2);
					checkByte(a, d);
				end
				"X": begin
					code = $fscanf(fd, "%h", d);
					requireArgs(code, 1);
					expQ.push_back(d);
				end
				"R": begin
					code = $fscanf(fd, "%d", n);
					requireArgs(code, 1);
					runProgram(n);
				end
				"Z": begin
					code = $fscanf(fd, "%d", n);
					requireArgs(code, 1);
					zeroChecks(n);
				end
				default: failNow($sformatf("unknown command %0s in verif/upStim.txt", cmd));
			endcase
		end
		$fclose(fd);
		$display("TEST PASS");
		$finish;
	end

endmodule
